//--- src.f
fix_pkg.sv
conv_pkg.sv
seq_num_tracker.sv
body_length_calc.sv
bin_to_ascii.sv
fix_len_ctrl.sv
fix_body_length.sv
tb_fix_body_length.sv

//--- tb_fix_body_length.sv
module tb_fix_body_length;

	timeunit 1ns;
	timeprecision 1ps;

	logic			clk = 1'b0;
	logic			reset_i;
	logic			start_i;
	fix_pkg::msg_type_t	msg_type_i;
	fix_pkg::target_len_t	target_len_i;
	conv_pkg::len_ascii_t	len_ascii_o;
	fix_pkg::seq_num_t	seq_num_o;
	logic			valid_o;
	logic			reject_o;
	logic			busy_o;

	integer			seed;
	int			model_seq;	// Sequence number the next valid message uses

	fix_body_length UUT (
		.clk		(clk),
		.reset_i	(reset_i),
		.start_i	(start_i),
		.msg_type_i	(msg_type_i),
		.target_len_i	(target_len_i),
		.len_ascii_o	(len_ascii_o),
		.seq_num_o	(seq_num_o),
		.valid_o	(valid_o),
		.reject_o	(reject_o),
		.busy_o		(busy_o)
	);

	always #4 clk = ~clk;

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic check_equal(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			stop_run($sformatf("ERROR: %s is 0x%h, expected 0x%h", name, actual, expected));
		end
	endtask

	function automatic int decimal_digits(input int value);
		int n;
		int v;
		n = 1;
		v = value;
		while (v >= 10) begin
			v = v / 10;
			n++;
		end
		return n;
	endfunction

	// BodyLength of the fields that the subsystem covers
	function automatic int model_length(input fix_pkg::msg_type_t t, input int target,
			input int seq);
		int len;
		len = 45 + decimal_digits(seq) + target;
		if (t == fix_pkg::MSG_LOGON) begin
			len = len + 10;	// EncryptMethod and HeartBtInt
		end
		return len;
	endfunction

	function automatic conv_pkg::len_ascii_t format_length(input int len);
		conv_pkg::len_ascii_t f;
		int h;
		int t;
		int u;
		h = len / 100;
		t = (len / 10) % 10;
		u = len % 10;
		f = '0;
		if (len >= 100) begin
			f.count = 2'd3;
			f.digits[7:0] = 8'(48 + h);
			f.digits[15:8] = 8'(48 + t);
			f.digits[23:16] = 8'(48 + u);
		end else if (len >= 10) begin
			f.count = 2'd2;
			f.digits[7:0] = 8'(48 + t);
			f.digits[15:8] = 8'(48 + u);
		end else begin
			f.count = 2'd1;
			f.digits[7:0] = 8'(48 + u);
		end
		return f;
	endfunction

	// Returns on the falling edge of the cycle after the accepting edge
	task automatic drive_start(input fix_pkg::msg_type_t t, input fix_pkg::target_len_t len);
		@(negedge clk);
		start_i = 1'b1;
		msg_type_i = t;
		target_len_i = len;
		@(negedge clk);
		start_i = 1'b0;
	endtask

	task automatic run_valid_message(input fix_pkg::msg_type_t t,
			input fix_pkg::target_len_t len, input logic start_while_busy);
		conv_pkg::len_ascii_t expected;
		int cycles;
		check_equal("seq_num_o", seq_num_o, model_seq);
		expected = format_length(model_length(t, int'(len), model_seq));
		drive_start(t, len);
		cycles = 1;
		check_equal("reject_o", reject_o, 0);
		while (valid_o !== 1'b1) begin
			check_equal("busy_o", busy_o, 1);
			if (cycles >= 40) begin
				stop_run("Timeout: valid_o did not rise within 40 cycles of start");
			end
			// A second start in the middle of a message must not start another one
			start_i = start_while_busy && (cycles == 4);
			msg_type_i = fix_pkg::MSG_LOGON;
			target_len_i = 6'd63;
			@(negedge clk);
			cycles++;
		end
		start_i = 1'b0;
		check_equal("valid_o latency", cycles, 12);
		check_equal("busy_o", busy_o, 1);
		check_equal("len_ascii_o.digits", len_ascii_o.digits, expected.digits);
		check_equal("len_ascii_o.count", len_ascii_o.count, expected.count);
		@(negedge clk);
		model_seq++;
		check_equal("valid_o", valid_o, 0);
		check_equal("busy_o", busy_o, 0);
		check_equal("seq_num_o", seq_num_o, model_seq);
		if (start_while_busy) begin
			repeat (16) begin
				@(negedge clk);
				check_equal("valid_o", valid_o, 0);
			end
			check_equal("seq_num_o", seq_num_o, model_seq);
		end
	endtask

	task automatic run_rejected_message(input fix_pkg::msg_type_t t,
			input fix_pkg::target_len_t len);
		drive_start(t, len);
		check_equal("reject_o", reject_o, 1);
		check_equal("valid_o", valid_o, 0);
		repeat (14) begin
			@(negedge clk);
			check_equal("reject_o", reject_o, 0);
			check_equal("valid_o", valid_o, 0);
		end
		check_equal("seq_num_o", seq_num_o, model_seq);
	endtask

	// One draw in four is an unknown code
	task automatic pick_type(output fix_pkg::msg_type_t t, output logic known);
		int r;
		r = $unsigned($random(seed)) % 4;
		known = 1'b1;
		case (r)
			0: t = fix_pkg::MSG_LOGON;
			1: t = fix_pkg::MSG_LOGOUT;
			2: t = fix_pkg::MSG_HEARTBEAT;
			default: begin
				known = 1'b0;
				t = 4'($random(seed));
				if (t == 4'd0 || t == 4'd1 || t == 4'd5) begin
					t = 4'hF;
				end
			end
		endcase
	endtask

	initial begin
		fix_pkg::msg_type_t	t;
		fix_pkg::target_len_t	len;
		logic			known;
		int			n;
		reset_i = 1'b1;
		start_i = 1'b0;
		msg_type_i = fix_pkg::MSG_HEARTBEAT;
		target_len_i = 6'd1;
		seed = 74;
		model_seq = 1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset_i = 1'b0;
		@(negedge clk);
		check_equal("valid_o", valid_o, 0);
		check_equal("reject_o", reject_o, 0);
		check_equal("busy_o", busy_o, 0);
		check_equal("seq_num_o", seq_num_o, 1);
		check_equal("len_ascii_o.digits", len_ascii_o.digits, 24'h000030);
		check_equal("len_ascii_o.count", len_ascii_o.count, 1);

		run_valid_message(fix_pkg::MSG_LOGON, 6'd20, 1'b0);
		run_valid_message(fix_pkg::MSG_HEARTBEAT, 6'd8, 1'b1);
		run_rejected_message(4'd9, 6'd12);

		// Enough messages to carry the counter past 9 and 99
		n = 0;
		while (model_seq <= 105 && n < 400) begin
			pick_type(t, known);
			len = 6'(1 + $unsigned($random(seed)) % 63);
			if (known) begin
				run_valid_message(t, len, 1'b0);
			end else begin
				run_rejected_message(t, len);
			end
			n++;
		end
		if (model_seq <= 100) begin
			stop_run("Sequence number never crossed 99 to 100 during the random run");
		end else begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule

//--- fix_body_length.sv
module fix_body_length (
	input	logic			clk,
	input	logic			reset_i,
	input	logic			start_i,
	input	fix_pkg::msg_type_t	msg_type_i,
	input	fix_pkg::target_len_t	target_len_i,
	output	conv_pkg::len_ascii_t	len_ascii_o,
	output	fix_pkg::seq_num_t	seq_num_o,
	output	logic			valid_o,
	output	logic			reject_o,
	output	logic			busy_o
);

	fix_pkg::msg_type_t	msg_type;	// Captured at start
	fix_pkg::target_len_t	target_len;
	fix_pkg::seq_digits_t	seq_digits;
	conv_pkg::body_len_t	body_len;
	logic			calc_en;
	logic			conv_start;
	logic			conv_done;
	logic			seq_adv;

	fix_len_ctrl u_ctrl (
		.clk		(clk),
		.reset_i	(reset_i),
		.start_i	(start_i),
		.msg_type_i	(msg_type_i),
		.target_len_i	(target_len_i),
		.conv_done_i	(conv_done),
		.msg_type_o	(msg_type),
		.target_len_o	(target_len),
		.calc_en_o	(calc_en),
		.conv_start_o	(conv_start),
		.seq_adv_o	(seq_adv),
		.valid_o	(valid_o),
		.reject_o	(reject_o),
		.busy_o		(busy_o)
	);

	seq_num_tracker u_seq (
		.clk		(clk),
		.reset_i	(reset_i),
		.seq_adv_i	(seq_adv),
		.seq_num_o	(seq_num_o),
		.seq_digits_o	(seq_digits)
	);

	body_length_calc u_calc (
		.clk		(clk),
		.reset_i	(reset_i),
		.calc_en_i	(calc_en),
		.msg_type_i	(msg_type),
		.seq_digits_i	(seq_digits),
		.target_len_i	(target_len),
		.body_len_o	(body_len)
	);

	bin_to_ascii u_conv (
		.clk		(clk),
		.reset_i	(reset_i),
		.start_i	(conv_start),
		.bin_i		(body_len),
		.done_o		(conv_done),
		.result_o	(len_ascii_o)
	);

endmodule

//--- fix_len_ctrl.sv
module fix_len_ctrl (
	input	logic			clk,
	input	logic			reset_i,
	input	logic			start_i,
	input	fix_pkg::msg_type_t	msg_type_i,
	input	fix_pkg::target_len_t	target_len_i,
	input	logic			conv_done_i,
	output	fix_pkg::msg_type_t	msg_type_o,
	output	fix_pkg::target_len_t	target_len_o,
	output	logic			calc_en_o,
	output	logic			conv_start_o,
	output	logic			seq_adv_o,
	output	logic			valid_o,
	output	logic			reject_o,
	output	logic			busy_o
);

	typedef enum logic [2:0] {IDLE, CALC, CONV_START, CONV_WAIT, DONE} ctrl_state_t;

	ctrl_state_t		state_q;
	ctrl_state_t		state_d;
	fix_pkg::msg_type_t	msg_type_q;
	fix_pkg::target_len_t	target_len_q;
	logic			type_ok;
	logic			accept;
	logic			reject_q;

	always_comb begin
		case (msg_type_i)
			fix_pkg::MSG_LOGON, fix_pkg::MSG_LOGOUT, fix_pkg::MSG_HEARTBEAT: type_ok = 1'b1;
			default: type_ok = 1'b0;
		endcase
	end

	assign accept = start_i && !busy_o;	// A start while busy is dropped

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE, DONE: begin
				// DONE lasts one cycle and takes a new start like IDLE
				state_d = (accept && type_ok) ? CALC : IDLE;
			end
			CALC: state_d = CONV_START;
			CONV_START: state_d = CONV_WAIT;
			CONV_WAIT: begin
				if (conv_done_i) begin
					state_d = DONE;
				end
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state_q <= IDLE;
			reject_q <= 1'b0;
		end else begin
			state_q <= state_d;
			reject_q <= accept && !type_ok;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			msg_type_q <= msg_type_i;
			target_len_q <= target_len_i;
		end
	end

	assign msg_type_o = msg_type_q;
	assign target_len_o = target_len_q;
	assign calc_en_o = (state_q == CALC);
	assign conv_start_o = (state_q == CONV_START);
	assign valid_o = (state_q == CONV_WAIT) && conv_done_i;
	assign seq_adv_o = valid_o;	// Next message uses the following number
	assign reject_o = reject_q;
	assign busy_o = (state_q != IDLE) && (state_q != DONE);

	a_valid_reject_excl: assert property (
		@(posedge clk) disable iff (reset_i)
		!(valid_o && reject_o)
	) else $error("valid_o and reject_o high together");

endmodule

//--- bin_to_ascii.sv
module bin_to_ascii (
	input	logic			clk,
	input	logic			reset_i,
	input	logic			start_i,
	input	conv_pkg::body_len_t	bin_i,
	output	logic			done_o,
	output	conv_pkg::len_ascii_t	result_o
);

	conv_pkg::body_len_t	bin_q;
	conv_pkg::bcd_word_t	bcd_q;
	conv_pkg::bcd_word_t	bcd_adj;
	conv_pkg::step_cnt_t	step_cnt_q;
	conv_pkg::len_ascii_t	fmt;
	conv_pkg::len_ascii_t	result_q;
	logic			active_q;
	logic			done_q;

	function automatic conv_pkg::ascii_char_t to_ascii(input conv_pkg::bcd_digit_t d);
		return {4'h3, d};	// '0' is 8'h30
	endfunction

	// Add 3 to every digit of 5 or more before the shift
	always_comb begin
		bcd_adj = bcd_q;
		for (int i = 0; i < conv_pkg::LEN_DIGITS; i++) begin
			if (bcd_q[i] >= 4'd5) begin
				bcd_adj[i] = bcd_q[i] + 4'd3;
			end
		end
	end

	// Drop leading zeros and place the first significant digit in byte 0
	always_comb begin
		fmt = '0;
		if (bcd_q[2] != '0) begin
			fmt.count = conv_pkg::digit_count_t'(3);
			fmt.digits[7:0] = to_ascii(bcd_q[2]);
			fmt.digits[15:8] = to_ascii(bcd_q[1]);
			fmt.digits[23:16] = to_ascii(bcd_q[0]);
		end else if (bcd_q[1] != '0) begin
			fmt.count = conv_pkg::digit_count_t'(2);
			fmt.digits[7:0] = to_ascii(bcd_q[1]);
			fmt.digits[15:8] = to_ascii(bcd_q[0]);
		end else begin
			fmt.count = conv_pkg::digit_count_t'(1);
			fmt.digits[7:0] = to_ascii(bcd_q[0]);
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			active_q <= 1'b0;
			done_q <= 1'b0;
			step_cnt_q <= '0;
			result_q <= conv_pkg::LEN_ASCII_RESET;
		end else begin
			done_q <= 1'b0;
			if (start_i) begin
				active_q <= 1'b1;
				step_cnt_q <= conv_pkg::step_cnt_t'(conv_pkg::SHIFT_STEPS);
			end else if (active_q && step_cnt_q != '0) begin
				step_cnt_q <= step_cnt_q - conv_pkg::step_cnt_t'(1);
			end else if (active_q) begin
				// All bits shifted in, publish the digits
				active_q <= 1'b0;
				done_q <= 1'b1;
				result_q <= fmt;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start_i) begin
			bin_q <= bin_i;
			bcd_q <= '0;
		end else if (active_q && step_cnt_q != '0) begin
			{bcd_q, bin_q} <= {bcd_adj, bin_q} << 1;
		end
	end

	assign done_o = done_q;
	assign result_o = result_q;

	a_no_done_on_start: assert property (
		@(posedge clk) disable iff (reset_i)
		start_i |-> !done_o
	) else $error("bin_to_ascii done in the cycle of a new start");

endmodule

//--- body_length_calc.sv
module body_length_calc (
	input	logic			clk,
	input	logic			reset_i,
	input	logic			calc_en_i,
	input	fix_pkg::msg_type_t	msg_type_i,
	input	fix_pkg::seq_digits_t	seq_digits_i,
	input	fix_pkg::target_len_t	target_len_i,
	output	conv_pkg::body_len_t	body_len_o
);

	conv_pkg::body_len_t	len_sum;
	conv_pkg::body_len_t	body_len_q;

	// Fixed fields plus the two variable value lengths
	always_comb begin
		len_sum = conv_pkg::body_len_t'(fix_pkg::BASE_LEN)
			+ conv_pkg::body_len_t'(seq_digits_i)
			+ conv_pkg::body_len_t'(target_len_i);
		if (msg_type_i == fix_pkg::MSG_LOGON) begin
			len_sum = len_sum + conv_pkg::body_len_t'(fix_pkg::LOGON_EXTRA_LEN);
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			body_len_q <= '0;
		end else if (calc_en_i) begin
			body_len_q <= len_sum;	// Held until the next message
		end
	end

	assign body_len_o = body_len_q;

	// The sum fits in three decimal digits for every legal input
	a_len_in_range: assert property (
		@(posedge clk) disable iff (reset_i)
		calc_en_i |=> (int'(body_len_o) <= fix_pkg::MAX_BODY_LEN)
	) else $error("BodyLength above %0d", fix_pkg::MAX_BODY_LEN);

endmodule

//--- seq_num_tracker.sv
module seq_num_tracker (
	input	logic			clk,
	input	logic			reset_i,
	input	logic			seq_adv_i,
	output	fix_pkg::seq_num_t	seq_num_o,
	output	fix_pkg::seq_digits_t	seq_digits_o
);

	fix_pkg::seq_num_t	seq_q;
	fix_pkg::seq_digits_t	digits;

	// FIX sessions start counting at 1
	always_ff @(posedge clk) begin
		if (reset_i) begin
			seq_q <= fix_pkg::seq_num_t'(1);
		end else if (seq_adv_i) begin
			seq_q <= seq_q + fix_pkg::seq_num_t'(1);
		end
	end

	// Count how many powers of ten the value reaches
	always_comb begin
		digits = fix_pkg::seq_digits_t'(1);
		for (int p = 1; p < fix_pkg::SEQ_MAX_DIGITS; p++) begin
			if (int'(seq_q) >= 10 ** p) begin
				digits = fix_pkg::seq_digits_t'(p + 1);
			end
		end
	end

	assign seq_num_o = seq_q;
	assign seq_digits_o = digits;

	a_digits_nonzero: assert property (
		@(posedge clk) disable iff (reset_i)
		seq_digits_o != '0
	) else $error("seq_num_tracker digit count is zero");

endmodule

//--- conv_pkg.sv
package conv_pkg;

	localparam int LEN_DIGITS = 3;	// 125 at most, three decimal digits
	localparam int SHIFT_STEPS = 8;	// One shift per bit of the binary length

	typedef logic [SHIFT_STEPS-1:0] body_len_t;
	typedef logic [3:0] bcd_digit_t;
	typedef bcd_digit_t [LEN_DIGITS-1:0] bcd_word_t;
	typedef logic [7:0] ascii_char_t;
	typedef logic [8*LEN_DIGITS-1:0] ascii_digits_t;	// Byte 0 holds the first digit
	typedef logic [1:0] digit_count_t;
	typedef logic [$clog2(SHIFT_STEPS+1)-1:0] step_cnt_t;

	typedef struct packed {
		ascii_digits_t digits;
		digit_count_t count;
	} len_ascii_t;

	// A single "0" until the first conversion
	localparam len_ascii_t LEN_ASCII_RESET = '{
		digits: ascii_digits_t'(8'h30),
		count: digit_count_t'(1)
	};

endpackage

//--- fix_pkg.sv
package fix_pkg;

	// Message type codes as they enter the subsystem
	typedef logic [3:0] msg_type_t;

	typedef logic [19:0] seq_num_t;		// MsgSeqNum value
	typedef logic [2:0] seq_digits_t;	// Decimal digits of MsgSeqNum, 1 to 7
	typedef logic [5:0] target_len_t;	// TargetCompID value length, 1 to 63

	localparam msg_type_t MSG_HEARTBEAT = 4'd0;	// MsgType "0"
	localparam msg_type_t MSG_LOGON = 4'd1;		// MsgType "A"
	localparam msg_type_t MSG_LOGOUT = 4'd5;	// MsgType "5"

	// Fixed part shared by all supported messages
	// Covers tags 34, 35, 49, 52 and 56 with their fixed value sizes
	localparam int BASE_LEN = 45;

	// EncryptMethod and HeartBtInt fields, sent with Logon only
	localparam int LOGON_EXTRA_LEN = 10;

	localparam int SEQ_MAX_DIGITS = 7;	// A 20 bit counter never exceeds 7 digits
	localparam int TARGET_MAX_LEN = 63;

	// Upper bound of BodyLength, reached by a Logon with the longest fields
	localparam int MAX_BODY_LEN = BASE_LEN + SEQ_MAX_DIGITS + TARGET_MAX_LEN
		+ LOGON_EXTRA_LEN;

endpackage
